//--- floppy_io_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared bus widths, byte type and port offsets for the I/O block
//////////////////////////////////////////////////////////////////////

`default_nettype none

package floppy_io_pkg;

    //////////////////////////////////////////////////////////////////////
    // bus geometry
    //////////////////////////////////////////////////////////////////////

    // cpu address bus width
    localparam int addr_width = 16;

    // timer offsets must stay inside the 256-byte window
    localparam int max_timers = 8;

    // one byte on the data bus, in timer counts and register outputs
    typedef logic [7:0] io_byte_t;

    //////////////////////////////////////////////////////////////////////
    // port offsets inside the io window
    //////////////////////////////////////////////////////////////////////

    // offsets keep the legacy helper cpu map, gaps are unmapped
    typedef enum logic [7:0] {
        // sd card chip select, write only
        port_mmca        = 8'd0,
        // spi data, write starts a transfer
        port_spdr        = 8'd1,
        // spi status, bit 0 busy
        port_spsr        = 8'd2,
        // key inputs, low six bits
        port_joy         = 8'd3,
        // first timer, the rest follow upward
        port_tmr_base    = 8'd7,
        // request byte from the disk controller
        port_cpu_request = 8'd9,
        // status byte back to the disk controller
        port_cpu_status  = 8'd10,
        // debug leds
        port_led         = 8'd16,
        // command returned from the on-screen menu
        port_osd_command = 8'd17
    } io_port_e;

endpackage

`default_nettype wire

//--- io_port_decoder.sv
//////////////////////////////////////////////////////////////////////
// io window decode, write-only control registers and load strobes
//////////////////////////////////////////////////////////////////////

`default_nettype none

module io_port_decoder #(
    parameter logic [floppy_io_pkg::addr_width-1:0] IOBASE = 16'hE000,
    parameter int NUM_TIMERS = 2
) (
    input  wire logic                                   clk,
    input  wire logic                                   reset_n,
    input  wire logic                                   ce,
    input  wire logic [floppy_io_pkg::addr_width-1:0]   addr,
    input  wire floppy_io_pkg::io_byte_t                wdata,
    input  wire logic                                   wr,
    output logic                                        io_hit,
    output floppy_io_pkg::io_byte_t                     io_offset,
    output logic [NUM_TIMERS-1:0]                       timer_load,
    output logic                                        spi_start,
    output floppy_io_pkg::io_byte_t                     leds,
    output logic                                        sd_cs,
    output floppy_io_pkg::io_byte_t                     osd_command,
    output floppy_io_pkg::io_byte_t                     cpu_status
);

    import floppy_io_pkg::*;

    logic [addr_width-1:0] io_rel;
    logic                  wr_en;

    //////////////////////////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////////////////////////

    // offset relative to the window base, hit when the upper part is zero
    always_comb
    begin
        io_rel    = addr - IOBASE;
        io_hit    = (addr >= IOBASE) && (io_rel[addr_width-1:8] == '0);
        io_offset = io_rel[7:0];
    end

    // qualified bus write into the window
    assign wr_en = ce && wr && io_hit;

    //////////////////////////////////////////////////////////////////////
    // strobes, valid during the write cycle
    //////////////////////////////////////////////////////////////////////

    assign spi_start = wr_en && (io_offset == port_spdr);

    // timers sit on consecutive offsets from port_tmr_base
    always_comb
    begin
        timer_load = '0;
        for (int i = 0; i < NUM_TIMERS; i++)
        begin
            if (wr_en && (io_offset == io_byte_t'(int'(port_tmr_base) + i)))
                timer_load[i] = 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // control registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            leds        <= '0;
            sd_cs       <= 1'b1;
            osd_command <= '0;
            cpu_status  <= '0;
        end
        else if (wr_en)
        begin
            case (io_offset)
                port_led:         leds        <= wdata;
                // card select is active low, idle high
                port_mmca:        sd_cs       <= wdata[0];
                port_osd_command: osd_command <= wdata;
                port_cpu_status:  cpu_status  <= wdata;
                default:          ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- countdown_timer.sv
//////////////////////////////////////////////////////////////////////
// loadable 8-bit countdown timer with prescaler
//////////////////////////////////////////////////////////////////////

`default_nettype none

module countdown_timer #(
    parameter int TICK_DIV = 4
) (
    input  wire logic                    clk,
    input  wire logic                    reset_n,
    input  wire logic                    load,
    input  wire floppy_io_pkg::io_byte_t load_value,
    output floppy_io_pkg::io_byte_t      count
);

    import floppy_io_pkg::*;

    localparam int presc_w = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [presc_w-1:0] presc;
    logic               tick;

    // last prescaler step of a period
    assign tick = (presc == presc_w'(TICK_DIV - 1));

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            presc <= '0;
            count <= '0;
        end
        else if (load)
        begin
            // reload restarts the period from the load edge
            presc <= '0;
            count <= load_value;
        end
        else
        begin
            if (tick)
                presc <= '0;
            else
                presc <= presc + 1'b1;

            // stop at zero, no wrap
            if (tick && (count != '0))
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- spi_byte_master.sv
//////////////////////////////////////////////////////////////////////
// spi mode 0 master, one byte out and one byte in per start
//////////////////////////////////////////////////////////////////////

`default_nettype none

module spi_byte_master #(
    parameter int SPI_HALF = 2
) (
    input  wire logic                    clk,
    input  wire logic                    reset_n,
    input  wire logic                    start,
    input  wire floppy_io_pkg::io_byte_t tx_data,
    input  wire logic                    miso,
    output logic                         sck,
    output logic                         mosi,
    output floppy_io_pkg::io_byte_t      rx_data,
    output logic                         busy
);

    import floppy_io_pkg::*;

    localparam int div_w = (SPI_HALF > 1) ? $clog2(SPI_HALF) : 1;

    logic [div_w-1:0] div;
    logic [2:0]       bit_cnt;
    logic             half_tick;
    io_byte_t         tx_shift;
    io_byte_t         rx_shift;

    // end of one sck half period
    assign half_tick = (div == div_w'(SPI_HALF - 1));

    //////////////////////////////////////////////////////////////////////
    // sequencing
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            sck     <= 1'b0;
            mosi    <= 1'b1;
            busy    <= 1'b0;
            div     <= '0;
            bit_cnt <= '0;
        end
        else if (!busy)
        begin
            if (start)
            begin
                busy    <= 1'b1;
                div     <= '0;
                bit_cnt <= '0;
                // msb must be on the line before the first rising sck
                mosi    <= tx_data[7];
            end
        end
        else if (half_tick)
        begin
            div <= '0;
            if (!sck)
            begin
                sck <= 1'b1;
            end
            else
            begin
                sck     <= 1'b0;
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 3'd7)
                begin
                    busy <= 1'b0;
                    mosi <= 1'b1;
                end
                else
                begin
                    mosi <= tx_shift[6];
                end
            end
        end
        else
        begin
            div <= div + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // shift registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!busy && start)
        begin
            tx_shift <= tx_data;
        end
        else if (busy && half_tick)
        begin
            if (!sck)
            begin
                // sample on rising sck
                rx_shift <= {rx_shift[6:0], miso};
            end
            else
            begin
                tx_shift <= {tx_shift[6:0], 1'b0};
                // eighth falling edge, byte complete
                if (bit_cnt == 3'd7)
                    rx_data <= rx_shift;
            end
        end
    end

endmodule

`default_nettype wire

//--- io_read_mux.sv
//////////////////////////////////////////////////////////////////////
// registered read-back mux for the io window
//////////////////////////////////////////////////////////////////////

`default_nettype none

module io_read_mux #(
    parameter int NUM_TIMERS = 2
) (
    input  wire logic                    clk,
    input  wire logic                    reset_n,
    input  wire logic                    io_hit,
    input  wire floppy_io_pkg::io_byte_t io_offset,
    input  wire logic [NUM_TIMERS*8-1:0] timer_counts,
    input  wire logic [5:0]              keys,
    input  wire floppy_io_pkg::io_byte_t spi_rx_data,
    input  wire logic                    spi_busy,
    input  wire floppy_io_pkg::io_byte_t cpu_request,
    output floppy_io_pkg::io_byte_t      rdata
);

    import floppy_io_pkg::*;

    io_byte_t rd_next;

    // source select, everything unmapped reads as ff
    always_comb
    begin
        rd_next = 8'hFF;
        if (io_hit)
        begin
            case (io_offset)
                port_spdr:        rd_next = spi_rx_data;
                port_spsr:        rd_next = {7'b0, spi_busy};
                port_joy:         rd_next = {2'b00, keys};
                port_cpu_request: rd_next = cpu_request;
                default:          rd_next = 8'hFF;
            endcase

            // timer counts, one byte each from port_tmr_base upward
            for (int i = 0; i < NUM_TIMERS; i++)
            begin
                if (io_offset == io_byte_t'(int'(port_tmr_base) + i))
                    rd_next = timer_counts[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            rdata <= 8'hFF;
        else
            rdata <= rd_next;
    end

endmodule

`default_nettype wire

//--- floppy_io.sv
//////////////////////////////////////////////////////////////////////
// top level of the helper cpu io block
// decoder, timers, sd card spi master and read-back mux
//////////////////////////////////////////////////////////////////////

`default_nettype none

module floppy_io #(
    parameter logic [floppy_io_pkg::addr_width-1:0] IOBASE = 16'hE000,
    parameter int NUM_TIMERS = 2,
    parameter int TICK_DIV   = 4,
    parameter int SPI_HALF   = 2
) (
    input  wire logic                                   clk,
    input  wire logic                                   reset_n,
    input  wire logic                                   ce,
    input  wire logic [floppy_io_pkg::addr_width-1:0]   addr,
    input  wire floppy_io_pkg::io_byte_t                wdata,
    input  wire logic                                   wr,
    input  wire logic [5:0]                             keys,
    input  wire floppy_io_pkg::io_byte_t                cpu_request,
    input  wire logic                                   miso,
    output floppy_io_pkg::io_byte_t                     rdata,
    output floppy_io_pkg::io_byte_t                     leds,
    output logic                                        sd_cs,
    output floppy_io_pkg::io_byte_t                     osd_command,
    output floppy_io_pkg::io_byte_t                     cpu_status,
    output logic                                        sck,
    output logic                                        mosi
);

    import floppy_io_pkg::*;

    logic                    io_hit;
    io_byte_t                io_offset;
    logic [NUM_TIMERS-1:0]   timer_load;
    logic                    spi_start;
    logic [NUM_TIMERS*8-1:0] timer_counts;
    io_byte_t                spi_rx_data;
    logic                    spi_busy;

    // timers must end below port_cpu_request
    if (NUM_TIMERS < 1 || NUM_TIMERS > max_timers ||
        NUM_TIMERS > int'(port_cpu_request) - int'(port_tmr_base))
    begin : g_bad_timers
        $error("NUM_TIMERS out of range for the port map");
    end

    io_port_decoder #(
        .IOBASE     (IOBASE),
        .NUM_TIMERS (NUM_TIMERS)
    ) decoder_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .ce          (ce),
        .addr        (addr),
        .wdata       (wdata),
        .wr          (wr),
        .io_hit      (io_hit),
        .io_offset   (io_offset),
        .timer_load  (timer_load),
        .spi_start   (spi_start),
        .leds        (leds),
        .sd_cs       (sd_cs),
        .osd_command (osd_command),
        .cpu_status  (cpu_status)
    );

    //////////////////////////////////////////////////////////////////////
    // timers, load data shared from the bus
    //////////////////////////////////////////////////////////////////////

    for (genvar t = 0; t < NUM_TIMERS; t++)
    begin : g_timer
        countdown_timer #(
            .TICK_DIV (TICK_DIV)
        ) timer_i (
            .clk        (clk),
            .reset_n    (reset_n),
            .load       (timer_load[t]),
            .load_value (wdata),
            .count      (timer_counts[t*8 +: 8])
        );
    end

    spi_byte_master #(
        .SPI_HALF (SPI_HALF)
    ) spi_i (
        .clk     (clk),
        .reset_n (reset_n),
        .start   (spi_start),
        .tx_data (wdata),
        .miso    (miso),
        .sck     (sck),
        .mosi    (mosi),
        .rx_data (spi_rx_data),
        .busy    (spi_busy)
    );

    io_read_mux #(
        .NUM_TIMERS (NUM_TIMERS)
    ) read_mux_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .io_hit       (io_hit),
        .io_offset    (io_offset),
        .timer_counts (timer_counts),
        .keys         (keys),
        .spi_rx_data  (spi_rx_data),
        .spi_busy     (spi_busy),
        .cpu_request  (cpu_request),
        .rdata        (rdata)
    );

endmodule

`default_nettype wire

//--- floppy_io_tb_checks.svh
//////////////////////////////////////////////////////////////////////
// pass and fail counters, typed compare tasks for the testbench
//////////////////////////////////////////////////////////////////////

`ifndef FLOPPY_IO_TB_CHECKS_SVH
`define FLOPPY_IO_TB_CHECKS_SVH

    int pass_count = 0;
    int fail_count = 0;

    // registered read data against the expected byte
    task automatic check_read(input logic [8*24-1:0] name, input io_byte_t expected);
        if (rdata === expected)
        begin
            pass_count++;
            $display("%0s ok, read %02h", name, rdata);
        end
        else
        begin
            fail_count++;
            $display("mismatch %0s expected %02h actual %02h", name, expected, rdata);
        end
    endtask

    // one register output against the expected byte
    task automatic check_reg(input logic [8*24-1:0] name, input string reg_name,
                             input io_byte_t expected, input io_byte_t actual);
        if (actual === expected)
        begin
            pass_count++;
            $display("%0s ok, %0s is %02h", name, reg_name, actual);
        end
        else
        begin
            fail_count++;
            $display("mismatch %0s %0s expected %02h actual %02h",
                     name, reg_name, expected, actual);
        end
    endtask

`endif

//--- floppy_io_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the io block, runs the records of the test file
// spi loopback through an inverter, watchdog sized from the records
//////////////////////////////////////////////////////////////////////

`default_nettype none

module floppy_io_tb;

    import floppy_io_pkg::*;

    localparam int max_records = 64;
    localparam logic [addr_width-1:0] io_base = 16'hE000;

    // mode 0 byte transfer, one sck pulse per bit
    localparam int sck_per_byte = 8;

    logic                  clk;
    logic                  reset_n;
    logic                  ce;
    logic [addr_width-1:0] addr;
    io_byte_t              wdata;
    logic                  wr;
    logic [5:0]            keys;
    io_byte_t              cpu_request;
    logic                  miso;
    io_byte_t              rdata;
    io_byte_t              leds;
    logic                  sd_cs;
    io_byte_t              osd_command;
    io_byte_t              cpu_status;
    logic                  sck;
    logic                  mosi;

    // test records, one entry per data line
    logic [8*24-1:0]       rec_name   [max_records];
    logic [8*8-1:0]        rec_op     [max_records];
    logic [addr_width-1:0] rec_addr   [max_records];
    io_byte_t              rec_data   [max_records];
    io_byte_t              rec_exp    [max_records];
    int                    rec_cycles [max_records];
    int                    num_records = 0;
    int                    limit_cycles = 20;
    int                    seed = 32'h715b_27aa;
    logic                  loaded = 1'b0;

    // sck rising edges, total and at the last received byte
    int                    sck_rises = 0;
    int                    sck_mark = 0;

    `include "floppy_io_tb_checks.svh"

    floppy_io #(
        .IOBASE   (io_base),
        .TICK_DIV (4),
        .SPI_HALF (2)
    ) dut_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .ce          (ce),
        .addr        (addr),
        .wdata       (wdata),
        .wr          (wr),
        .keys        (keys),
        .cpu_request (cpu_request),
        .miso        (miso),
        .rdata       (rdata),
        .leds        (leds),
        .sd_cs       (sd_cs),
        .osd_command (osd_command),
        .cpu_status  (cpu_status),
        .sck         (sck),
        .mosi        (mosi)
    );

    // inverted loopback, received byte is the complement of the sent one
    assign miso = ~mosi;

    always @(posedge sck)
        sck_rises++;

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // record file
    //////////////////////////////////////////////////////////////////////

    // lines that do not parse into six fields are comments
    task automatic load_tests();
        int               fd;
        int               n;
        logic [8*128-1:0] line;
        fd = $fopen("floppy_io_tests.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the test file floppy_io_tests.txt");
            fail_count++;
            return;
        end
        while (!$feof(fd) && num_records < max_records)
        begin
            line = '0;
            n = $fgets(line, fd);
            n = $sscanf(line, "%s %s %h %h %h %d", rec_name[num_records],
                        rec_op[num_records], rec_addr[num_records], rec_data[num_records],
                        rec_exp[num_records], rec_cycles[num_records]);
            if (n == 6)
            begin
                limit_cycles += rec_cycles[num_records] + 20;
                num_records++;
            end
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////////////////////////
    // one record, entered and left on a falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic run_record(input int i);
        logic [8*24-1:0] name;
        name = rec_name[i];
        repeat (rec_cycles[i]) @(negedge clk);
        case (rec_op[i])
            "wr", "wrnce":
            begin
                ce    = (rec_op[i] == "wr");
                wr    = 1'b1;
                addr  = rec_addr[i];
                wdata = rec_data[i];
                @(negedge clk);
                ce    = 1'b0;
                wr    = 1'b0;
                addr  = '0;
                $display("%0s done", name);
            end
            "rd", "rdkeys", "rdreq":
            begin
                ce   = 1'b1;
                addr = rec_addr[i];
                @(negedge clk);
                // key port carries six bits, zeros above
                if (rec_op[i] == "rdkeys")
                    check_read(name, {2'b00, keys});
                else if (rec_op[i] == "rdreq")
                    check_read(name, cpu_request);
                else
                    check_read(name, rec_exp[i]);
                // a received byte took exactly eight sck pulses
                if (rec_addr[i] == io_base + addr_width'(port_spdr))
                begin
                    check_reg(name, "sck pulses", io_byte_t'(sck_per_byte),
                              io_byte_t'(sck_rises - sck_mark));
                    sck_mark = sck_rises;
                end
                ce   = 1'b0;
                addr = '0;
            end
            "led":   check_reg(name, "leds", rec_exp[i], leds);
            "cs":    check_reg(name, "sd_cs", rec_exp[i], {7'b0, sd_cs});
            "osd":   check_reg(name, "osd_command", rec_exp[i], osd_command);
            "sts":   check_reg(name, "cpu_status", rec_exp[i], cpu_status);
            "inp":
            begin
                keys        = 6'($random(seed));
                cpu_request = 8'($random(seed));
                $display("%0s done, keys %02h request %02h", name, keys, cpu_request);
            end
            "wait":  $display("%0s done", name);
            default:
            begin
                fail_count++;
                $display("%0s has an unknown operation %0s", name, rec_op[i]);
            end
        endcase
    endtask

    initial
    begin
        reset_n     = 1'b0;
        ce          = 1'b0;
        addr        = '0;
        wdata       = '0;
        wr          = 1'b0;
        keys        = '0;
        cpu_request = '0;
        load_tests();
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        for (int i = 0; i < num_records; i++)
            run_record(i);
        if (num_records == 0)
        begin
            fail_count++;
            $display("no test records were found");
        end
        $display("records %0d, passed %0d, failed %0d", num_records, pass_count, fail_count);
        if (fail_count == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    // watchdog, reset plus idle cycles plus slack per record
    initial
    begin
        wait (loaded);
        repeat (limit_cycles + 9) @(posedge clk);
        $display("timeout, the records did not finish within %0d cycles", limit_cycles);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- floppy_io_tests.txt
# columns: name op addr data expect cycles, hex except cycles (idle clocks before the op)
# ops: wr rd led cs osd sts wait wrnce inp rdkeys rdreq
rst_rdata      rd     0000 00 ff 0
rst_leds       led    0000 00 00 0
rst_cs         cs     0000 00 01 0
rst_osd        osd    0000 00 00 0
rst_sts        sts    0000 00 00 0
rst_tmr0       rd     e007 00 00 0
rst_tmr1       rd     e008 00 00 0
rst_spsr       rd     e002 00 00 0
wr_led         wr     e010 5a 00 0
chk_led        led    0000 00 5a 0
wr_cs_low      wr     e000 fe 00 0
chk_cs_low     cs     0000 00 00 0
wr_osd         wr     e011 3c 00 0
chk_osd        osd    0000 00 3c 0
wr_sts         wr     e00a 81 00 0
chk_sts        sts    0000 00 81 0
nce_led        wrnce  e010 ff 00 0
chk_nce_led    led    0000 00 5a 0
below_led      wr     d010 ff 00 0
above_led      wr     e110 ff 00 0
chk_out_led    led    0000 00 5a 0
wr_cs_high     wr     e000 01 00 0
chk_cs_high    cs     0000 00 01 0
set_inputs     inp    0000 00 00 0
rd_keys        rdkeys e003 00 00 0
rd_request     rdreq  e009 00 00 0
rd_unmapped    rd     e004 00 ff 0
rd_outside     rd     dfff 00 ff 0
ld_tmr0        wr     e007 05 00 0
ld_tmr1        wr     e008 03 00 0
tmr0_k3        rd     e007 00 05 2
tmr1_k3        rd     e008 00 03 0
tmr0_k5        rd     e007 00 04 0
tmr1_k7        rd     e008 00 02 2
tmr0_k19       rd     e007 00 01 10
tmr1_k19       rd     e008 00 00 0
tmr0_k31       rd     e007 00 00 10
reload_tmr1    wr     e008 09 00 0
tmr0_held      rd     e007 00 00 0
tmr1_k1        rd     e008 00 09 0
tmr1_k8        rd     e008 00 07 6
spi_tx_a5      wr     e001 a5 00 0
spi_busy       rd     e002 00 01 0
spi_ignored    wr     e001 3c 00 2
spi_busy_late  rd     e002 00 01 25
spi_idle       rd     e002 00 00 2
spi_rx_5a      rd     e001 00 5a 0
spi_tx_3c      wr     e001 3c 00 0
spi_wait       wait   0000 00 00 34
spi_rx_c3      rd     e001 00 c3 0

//--- floppy_io.f
+incdir+.
floppy_io_pkg.sv
io_port_decoder.sv
countdown_timer.sv
spi_byte_master.sv
io_read_mux.sv
floppy_io.sv
floppy_io_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the floppy_io testbench with verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f floppy_io.f --top-module floppy_io_tb \
    -o floppy_io_sim &&
out=$(./obj_dir/floppy_io_sim) &&
echo "$out" &&
echo "$out" | grep -qx "Test OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
